// File: Bender.yml
package:
  name: vstore

sources:
  - files:
      - common/vstore_pkg.sv
      - design/beat_fifo.sv
      - store_unit/vstore_sequencer.sv
      - data_mem/data_mem_banks.sv
      - design/vstore_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_vstore_top.sv

// File: common/vstore_pkg.sv
// shared types for the vector store path
// VLEN is fixed at 128, the element width comes from the opcode alone
// lmul codes other than 0, 1 and 2 are treated as a single register
package vstore_pkg;

    localparam int addr_bits     = 8;
    localparam int lanes         = 4;
    localparam int lane_bits     = 2;
    localparam int word_bits     = 32;
    localparam int group_bits    = 512;
    localparam int fifo_depth    = 4;
    localparam int fifo_ptr_bits = 2;

    // up to 16 beats per store, four elements each
    localparam int idx_bits = 4;

    // lmul codes with their own register count
    localparam logic [2:0] lmul_m2 = 3'd1;
    localparam logic [2:0] lmul_m4 = 3'd2;

    typedef logic [word_bits-1:0]          word_t;
    typedef logic [addr_bits-1:0]          addr_t;
    typedef logic [4:0]                    stride_t;
    typedef logic [group_bits-1:0]         vgroup_t;
    typedef logic [idx_bits-1:0]           beat_idx_t;
    typedef logic [idx_bits+lane_bits-1:0] elem_idx_t;

    typedef enum logic [2:0] {
        vse8   = 3'd0,
        vse16  = 3'd1,
        vse32  = 3'd2,
        vsse8  = 3'd4,
        vsse16 = 3'd5,
        vsse32 = 3'd6
    } store_op_e;

    typedef struct packed {
        store_op_e  op;
        logic [2:0] lmul;
        addr_t      addr;
        stride_t    stride;
        vgroup_t    data;
    } store_cmd_t;

    // one write to all four banks, lane k goes to bank k
    typedef struct packed {
        addr_t [lanes-1:0] addr;
        word_t [lanes-1:0] data;
        logic              last;
    } store_beat_t;

    typedef enum logic {
        st_idle,
        st_emit
    } seq_state_e;

endpackage

// File: data_mem/data_mem_banks.sv
// four banks of 256 words, one beat writes all four lanes at once
// a read request takes the cycle and holds off the write
// bank contents are not cleared by reset
`timescale 1ns/1ps

module data_mem_banks import vstore_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        empty,
    input  store_beat_t beat,
    output logic        pop,
    output logic        done,
    input  logic        rd_en,
    input  logic [1:0]  rd_bank,
    input  addr_t       rd_addr,
    output word_t       rd_data
);

    word_t bank [lanes][2**addr_bits];

    // reads win over writes
    assign pop = !empty && !rd_en;

    always_ff @(posedge clk) begin
        if (pop) begin
            for (int k = 0; k < lanes; k++) begin
                bank[k][beat.addr[k]] <= beat.data[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= bank[rd_bank][rd_addr];
        end
    end

    // one cycle after the last beat lands
    always_ff @(posedge clk) begin
        if (!nrst) begin
            done <= 1'b0;
        end else begin
            done <= pop && beat.last;
        end
    end

endmodule

// File: design/beat_fifo.sv
// four-entry beat FIFO, head is visible the cycle after the push
// push while full and pop while empty are not expected
`timescale 1ns/1ps

module beat_fifo import vstore_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        push,
    input  store_beat_t din,
    input  logic        pop,
    output store_beat_t dout,
    output logic        full,
    output logic        empty
);

    store_beat_t              mem [fifo_depth];
    logic [fifo_ptr_bits-1:0] wr_ptr;
    logic [fifo_ptr_bits-1:0] rd_ptr;
    logic [fifo_ptr_bits:0]   count;

    assign dout  = mem[rd_ptr];
    assign full  = (count == fifo_depth);
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// File: design/vstore_top.sv
// vector store path: sequencer, beat FIFO and four-bank data memory
// start is ignored while busy is high, done pulses once per store
// an external read stalls the bank writes for that cycle
`timescale 1ns/1ps

module vstore_top import vstore_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       start,
    input  store_cmd_t cmd,
    output logic       busy,
    output logic       done,
    input  logic       rd_en,
    input  logic [1:0] rd_bank,
    input  addr_t      rd_addr,
    output word_t      rd_data
);

    logic        push;
    logic        pop;
    logic        full;
    logic        empty;
    store_beat_t seq_beat;
    store_beat_t head_beat;

    vstore_sequencer vstore_sequencer_inst (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .cmd        (cmd),
        .full       (full),
        .busy       (busy),
        .push       (push),
        .beat       (seq_beat),
        .write_done (done)
    );

    beat_fifo beat_fifo_inst (
        .clk   (clk),
        .nrst  (nrst),
        .push  (push),
        .din   (seq_beat),
        .pop   (pop),
        .dout  (head_beat),
        .full  (full),
        .empty (empty)
    );

    data_mem_banks data_mem_banks_inst (
        .clk     (clk),
        .nrst    (nrst),
        .empty   (empty),
        .beat    (head_beat),
        .pop     (pop),
        .done    (done),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: store_unit/vstore_sequencer.sv
// one store command at a time, the next start is taken only after write_done
// strided elements are sign-extended to 32 bits, addresses wrap at 256
`timescale 1ns/1ps

module vstore_sequencer import vstore_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        start,
    input  store_cmd_t  cmd,
    input  logic        full,
    output logic        busy,
    output logic        push,
    output store_beat_t beat,
    input  logic        write_done
);

    seq_state_e state;
    store_cmd_t cmd_q;
    beat_idx_t  idx;
    beat_idx_t  last_idx;
    logic       busy_q;
    logic       accept;

    // number of beats minus one
    function automatic beat_idx_t decode_last(store_cmd_t c);
        beat_idx_t per_reg;
        beat_idx_t regs;
        case (c.op)
            vsse8:   per_reg = 4;
            vsse16:  per_reg = 2;
            default: per_reg = 1;
        endcase
        case (c.lmul)
            lmul_m2: regs = 2;
            lmul_m4: regs = 4;
            default: regs = 1;
        endcase
        return beat_idx_t'(per_reg * regs - 1);
    endfunction

    function automatic addr_t lane_addr(store_cmd_t c, elem_idx_t j);
        case (c.op)
            vsse8, vsse16, vsse32: return addr_t'(c.addr + j * c.stride);
            default:               return addr_t'(c.addr + j);
        endcase
    endfunction

    // unit stride moves raw words, strided moves one element per lane
    function automatic word_t lane_word(store_cmd_t c, elem_idx_t j);
        logic [7:0]  b;
        logic [15:0] h;
        b = c.data[j*8 +: 8];
        h = c.data[j*16 +: 16];
        case (c.op)
            vsse8:   return {{24{b[7]}}, b};
            vsse16:  return {{16{h[15]}}, h};
            default: return c.data[j*32 +: 32];
        endcase
    endfunction

    // busy drops together with the done pulse
    assign busy   = busy_q && !write_done;
    assign accept = start && !busy;
    assign push   = (state == st_emit) && !full;

    always_comb begin
        beat.last = (idx == last_idx);
        for (int k = 0; k < lanes; k++) begin
            beat.addr[k] = lane_addr(cmd_q, {idx, lane_bits'(k)});
            beat.data[k] = lane_word(cmd_q, {idx, lane_bits'(k)});
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state  <= st_idle;
            idx    <= '0;
            busy_q <= 1'b0;
        end else begin
            if (write_done) begin
                busy_q <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (accept) begin
                        state  <= st_emit;
                        idx    <= '0;
                        busy_q <= 1'b1;
                    end
                end
                st_emit: begin
                    // hold the index while the FIFO is full
                    if (push) begin
                        if (idx == last_idx) begin
                            state <= st_idle;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q    <= cmd;
            last_idx <= decode_last(cmd);
        end
    end

endmodule

// File: verif/vstore_model.svh
// reference rules for one store: beat count, element address, element word
// element j of a store is written to bank j mod 4, a later element overwrites an earlier one
`ifndef VSTORE_MODEL_SVH
`define VSTORE_MODEL_SVH

// registers in the group, codes 3 to 7 count as one
function automatic int model_num_regs(logic [2:0] lmul);
    case (lmul)
        3'd1:    return 2;
        3'd2:    return 4;
        default: return 1;
    endcase
endfunction

// four elements per beat
function automatic int model_num_beats(store_cmd_t c);
    case (c.op)
        vsse8:   return (16 / 4) * model_num_regs(c.lmul);
        vsse16:  return (8 / 4) * model_num_regs(c.lmul);
        default: return model_num_regs(c.lmul);
    endcase
endfunction

function automatic addr_t model_elem_addr(store_cmd_t c, int j);
    int a;
    if (c.op inside {vsse8, vsse16, vsse32}) begin
        a = int'(c.addr) + j * int'(c.stride);
    end else begin
        a = int'(c.addr) + j;
    end
    return addr_t'(a % 256);
endfunction

// strided elements widen with their sign, unit stride moves raw words
function automatic word_t model_elem_word(store_cmd_t c, int j);
    int v;
    case (c.op)
        vsse8:   v = $signed(c.data[j*8 +: 8]);
        vsse16:  v = $signed(c.data[j*16 +: 16]);
        default: v = c.data[j*32 +: 32];
    endcase
    return word_t'(v);
endfunction

`endif

// File: verif/tb_vstore_top.sv
// self-checking testbench for the vector store path
// memory is first filled by unit-stride stores, so every bank word is known
`timescale 1ns/1ps

module tb_vstore_top import vstore_pkg::*; ();

    localparam int done_timeout = 200;

    logic       clk;
    logic       nrst;
    logic       start;
    store_cmd_t cmd;
    logic       busy;
    logic       done;
    logic       rd_en;
    logic [1:0] rd_bank;
    addr_t      rd_addr;
    word_t      rd_data;

    // expected bank contents and the words hit by the last store
    word_t shadow [lanes][256];
    bit    touched [lanes][256];

    `include "vstore_model.svh"

    vstore_top vstore_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_failure(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic void apply_model(store_cmd_t c);
        for (int b = 0; b < lanes; b++) begin
            for (int a = 0; a < 256; a++) begin
                touched[b][a] = 1'b0;
            end
        end
        for (int j = 0; j < lanes * model_num_beats(c); j++) begin
            shadow[j % lanes][model_elem_addr(c, j)] = model_elem_word(c, j);
            touched[j % lanes][model_elem_addr(c, j)] = 1'b1;
        end
    endfunction

    function automatic store_cmd_t random_cmd(store_op_e op, logic [2:0] lmul);
        store_cmd_t c;
        c.op     = op;
        c.lmul   = lmul;
        c.addr   = addr_t'($urandom);
        c.stride = stride_t'($urandom);
        for (int w = 0; w < group_bits / 32; w++) begin
            c.data[w*32 +: 32] = $urandom;
        end
        return c;
    endfunction

    // rd_data is registered, so it is taken one falling edge later
    task automatic read_word(int b, int a, output word_t data);
        @(negedge clk);
        rd_en   = 1'b1;
        rd_bank = b[1:0];
        rd_addr = a[7:0];
        @(negedge clk);
        rd_en = 1'b0;
        data  = rd_data;
    endtask

    task automatic read_back(string name, bit all_words);
        word_t data;
        for (int b = 0; b < lanes; b++) begin
            for (int a = 0; a < 256; a++) begin
                if (all_words || touched[b][a]) begin
                    read_word(b, a, data);
                    check_value(name, shadow[b][a], data);
                end
            end
        end
    endtask

    // optional random reads and extra start pulses on odd cycles of the store
    task automatic run_store(string name, store_cmd_t c, bit reads, bit extra_starts);
        int   cycles;
        logic done_seen;
        apply_model(c);
        @(negedge clk);
        cmd       = c;
        start     = 1'b1;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            cycles++;
            done_seen = done;
            if (!done_seen && cycles > done_timeout) begin
                stop_on_failure($sformatf("%s: done never came after start", name));
            end
            // busy stays high until the done cycle
            check_value({name, " busy"}, word_t'(!done_seen), word_t'(busy));
            start = !done_seen && extra_starts && (cycles % 2 == 1);
            if (start) begin
                cmd = random_cmd(vse32, 3'd2);
            end
            rd_en   = !done_seen && reads && ($urandom_range(1, 0) == 1);
            rd_bank = 2'($urandom);
            rd_addr = addr_t'($urandom);
        end
        if (!reads) begin
            check_value({name, " latency"}, word_t'(model_num_beats(c) + 2), word_t'(cycles));
        end
    endtask

    // 64 unit-stride stores cover every word of every bank
    task automatic fill_memory();
        store_cmd_t c;
        for (int m = 0; m < 64; m++) begin
            c      = random_cmd(vse32, 3'd2);
            c.addr = addr_t'(16 * (m % 16) + m / 16);
            run_store("fill", c, 1'b0, 1'b0);
        end
        read_back("fill", 1'b1);
    endtask

    initial begin
        store_cmd_t c;
        void'($urandom(50941));
        nrst    = 1'b0;
        start   = 1'b0;
        cmd     = '0;
        rd_en   = 1'b0;
        rd_bank = '0;
        rd_addr = '0;
        repeat (8) @(negedge clk);
        nrst = 1'b1;
        fill_memory();
        for (int o = 0; o < 3; o++) begin
            for (int l = 0; l < 3; l++) begin
                c = random_cmd(store_op_e'(o), 3'(l));
                run_store("unit stride", c, 1'b0, 1'b0);
                read_back("unit stride", 1'b0);
                c = random_cmd(store_op_e'(o + 4), 3'(l));
                run_store("strided", c, 1'b0, 1'b0);
                read_back("strided", 1'b0);
            end
        end
        fill_memory();
        c        = random_cmd(vsse8, 3'd2);
        c.addr   = 8'd200;
        c.stride = 5'd31;
        run_store("stride wrap", c, 1'b0, 1'b0);
        read_back("untouched words", 1'b1);
        for (int n = 0; n < 6; n++) begin
            c = random_cmd(store_op_e'($urandom_range(2, 0) + 4 * $urandom_range(1, 0)), 3'd2);
            run_store("read traffic", c, 1'b1, 1'b0);
            read_back("read traffic", 1'b1);
        end
        c = random_cmd(vsse16, 3'd1);
        run_store("start while busy", c, 1'b0, 1'b1);
        read_back("start while busy", 1'b1);
        for (int l = 3; l < 8; l++) begin
            c = random_cmd(store_op_e'($urandom_range(2, 0) + 4 * $urandom_range(1, 0)), 3'(l));
            run_store("unsupported lmul", c, 1'b0, 1'b0);
            read_back("unsupported lmul", 1'b0);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: vstore.f
+incdir+verif
common/vstore_pkg.sv
design/beat_fifo.sv
store_unit/vstore_sequencer.sv
data_mem/data_mem_banks.sv
design/vstore_top.sv
verif/tb_vstore_top.sv
